/* hw/synth_pkg.sv */
package synth_pkg;

    // -------------------------------------------------------------------------
    // sample timing and datapath widths
    // -------------------------------------------------------------------------
    localparam int SAMPLE_DIV = 32;    // clock cycles per audio sample
    localparam int PHASE_W = 24;
    localparam int WAVE_W = 21;        // three 19-bit shapes summed
    localparam int MIX_W = 23;         // four voices summed
    localparam int OUT_W = 12;
    localparam int SHIFT_W = 5;

    // -------------------------------------------------------------------------
    // state-variable filter, fixed point with SVF_FRAC fraction bits
    // -------------------------------------------------------------------------
    localparam int SVF_FRAC = 16;
    localparam logic signed [WAVE_W-1:0] SVF_F = 21'sd16384;  // 0.25
    localparam logic signed [WAVE_W-1:0] SVF_Q = 21'sd92682;  // ~1.414, flat passband

    // -------------------------------------------------------------------------
    // envelope
    // -------------------------------------------------------------------------
    localparam int ENV_W = 12;
    localparam logic [ENV_W-1:0] ENV_MAX = 12'd4095;
    localparam logic [ENV_W-1:0] ATTACK_STEP = 12'd256;
    localparam logic [ENV_W-1:0] DECAY_STEP = 12'd128;
    localparam logic [ENV_W-1:0] SUSTAIN_LEVEL = 12'd2047;
    localparam logic [ENV_W-1:0] RELEASE_STEP = 12'd128;

    // envelope FSM encoding
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
    localparam logic [STATE_W-1:0] ST_ATTACK = 3'd1;
    localparam logic [STATE_W-1:0] ST_DECAY = 3'd2;
    localparam logic [STATE_W-1:0] ST_SUSTAIN = 3'd3;
    localparam logic [STATE_W-1:0] ST_RELEASE = 3'd4;

endpackage

/* hw/nco.sv */
`timescale 1ns/1ps

module nco (
    input  logic clk,
    input  logic rst,
    input  logic [synth_pkg::PHASE_W-1:0] increment_1,
    input  logic [synth_pkg::PHASE_W-1:0] increment_2,
    input  logic [synth_pkg::PHASE_W-1:0] increment_3,
    input  logic [synth_pkg::PHASE_W-1:0] increment_4,
    input  logic [synth_pkg::SHIFT_W-1:0] square_shift,
    input  logic [synth_pkg::SHIFT_W-1:0] triangle_shift,
    input  logic [synth_pkg::SHIFT_W-1:0] sawtooth_shift,
    output logic signed [synth_pkg::WAVE_W-1:0] wave_1,
    output logic signed [synth_pkg::WAVE_W-1:0] wave_2,
    output logic signed [synth_pkg::WAVE_W-1:0] wave_3,
    output logic signed [synth_pkg::WAVE_W-1:0] wave_4,
    output logic valid
);
    logic [$clog2(synth_pkg::SAMPLE_DIV)-1:0] cnt;
    logic [synth_pkg::PHASE_W-1:0] inc [4];
    logic [synth_pkg::PHASE_W-1:0] phase [4];
    logic signed [synth_pkg::WAVE_W-1:0] wave [4];

    // sign-extend one shape and attenuate it, all ones mutes it
    function automatic logic signed [synth_pkg::WAVE_W-1:0] atten(
        input logic signed [synth_pkg::WAVE_W-3:0] s,
        input logic [synth_pkg::SHIFT_W-1:0] sh
    );
        logic signed [synth_pkg::WAVE_W-1:0] ext;
        ext = s;
        if (sh == '1)
            atten = '0;
        else
            atten = ext >>> sh;
    endfunction

    function automatic logic signed [synth_pkg::WAVE_W-1:0] mix(
        input logic [synth_pkg::PHASE_W-1:0] ph
    );
        logic signed [synth_pkg::WAVE_W-3:0] saw;
        logic signed [synth_pkg::WAVE_W-3:0] sqr;
        logic signed [synth_pkg::WAVE_W-3:0] tri_w;
        logic [synth_pkg::WAVE_W-4:0] fold;
        saw = ph[synth_pkg::PHASE_W-1 -: synth_pkg::WAVE_W-2];
        fold = ph[synth_pkg::PHASE_W-2 -: synth_pkg::WAVE_W-3];
        if (ph[synth_pkg::PHASE_W-1])
            fold = ~fold;                                   // falling half
        tri_w = {~fold[synth_pkg::WAVE_W-4], fold[synth_pkg::WAVE_W-5:0], 1'b0};
        if (ph[synth_pkg::PHASE_W-1])
            sqr = {1'b1, {(synth_pkg::WAVE_W-4){1'b0}}, 1'b1};   // -full scale
        else
            sqr = {1'b0, {(synth_pkg::WAVE_W-3){1'b1}}};         // +full scale
        mix = atten(sqr, square_shift) + atten(tri_w, triangle_shift)
            + atten(saw, sawtooth_shift);
    endfunction

    assign inc = '{increment_1, increment_2, increment_3, increment_4};

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            valid <= 1'b0;
            for (int i = 0; i < 4; i++)
                phase[i] <= '0;
        end else begin
            valid <= (cnt == synth_pkg::SAMPLE_DIV - 1);
            if (cnt == synth_pkg::SAMPLE_DIV - 1) begin
                cnt <= '0;
                for (int i = 0; i < 4; i++) begin
                    phase[i] <= phase[i] + inc[i];
                    wave[i] <= mix(phase[i] + inc[i]);
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign wave_1 = wave[0];
    assign wave_2 = wave[1];
    assign wave_3 = wave[2];
    assign wave_4 = wave[3];

endmodule

/* hw/svf.sv */
`timescale 1ns/1ps

module svf (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic signed [synth_pkg::WAVE_W-1:0] x,
    output logic signed [synth_pkg::WAVE_W-1:0] y,
    output logic out_valid
);
    logic signed [synth_pkg::WAVE_W-1:0] band;
    logic signed [synth_pkg::WAVE_W-1:0] low;
    logic signed [synth_pkg::WAVE_W-1:0] hp;
    logic signed [synth_pkg::WAVE_W-1:0] band_next;
    logic signed [synth_pkg::WAVE_W-1:0] low_next;
    logic signed [2*synth_pkg::WAVE_W-1:0] q_band;
    logic signed [2*synth_pkg::WAVE_W-1:0] hp_full;
    logic signed [2*synth_pkg::WAVE_W-1:0] f_hp;
    logic signed [2*synth_pkg::WAVE_W-1:0] band_full;
    logic signed [2*synth_pkg::WAVE_W-1:0] f_band;
    logic signed [2*synth_pkg::WAVE_W-1:0] low_full;
    logic hp_valid;

    function automatic logic signed [synth_pkg::WAVE_W-1:0] sat(
        input logic signed [2*synth_pkg::WAVE_W-1:0] v
    );
        if (v > 2**(synth_pkg::WAVE_W-1) - 1)
            sat = {1'b0, {(synth_pkg::WAVE_W-1){1'b1}}};
        else if (v < -(2**(synth_pkg::WAVE_W-1)))
            sat = {1'b1, {(synth_pkg::WAVE_W-1){1'b0}}};
        else
            sat = v[synth_pkg::WAVE_W-1:0];
    endfunction

    // stage one, high-pass from input and both states
    assign q_band = (synth_pkg::SVF_Q * band) >>> synth_pkg::SVF_FRAC;
    assign hp_full = x - low - q_band;

    // stage two, band then low integrate
    assign f_hp = (synth_pkg::SVF_F * hp) >>> synth_pkg::SVF_FRAC;
    assign band_full = band + f_hp;
    assign band_next = sat(band_full);
    assign f_band = (synth_pkg::SVF_F * band_next) >>> synth_pkg::SVF_FRAC;
    assign low_full = low + f_band;
    assign low_next = sat(low_full);

    always_ff @(posedge clk) begin
        if (rst) begin
            hp_valid <= 1'b0;
            out_valid <= 1'b0;
            band <= '0;
            low <= '0;
        end else begin
            hp_valid <= in_valid;
            out_valid <= hp_valid;
            if (in_valid)
                hp <= sat(hp_full);
            if (hp_valid) begin
                band <= band_next;
                low <= low_next;
                y <= low_next;          // low-pass tap
            end
        end
    end

endmodule

/* hw/adsr.sv */
`timescale 1ns/1ps

module adsr (
    input  logic clk,
    input  logic rst,
    input  logic global_reset,
    input  logic in_valid,
    input  logic signed [synth_pkg::WAVE_W-1:0] wave_in,
    input  logic note_start,
    input  logic note_release,
    input  logic note_reset,
    output logic signed [synth_pkg::WAVE_W-1:0] wave_out,
    output logic note_finished,
    output logic out_valid
);
    logic [synth_pkg::STATE_W-1:0] state;
    logic [synth_pkg::ENV_W-1:0] level;
    logic start_p;
    logic release_p;
    logic reset_p;
    logic step_valid;
    logic fin_d;
    logic signed [synth_pkg::WAVE_W-1:0] wave_d;
    logic signed [synth_pkg::WAVE_W+synth_pkg::ENV_W:0] prod;

    assign prod = wave_d * $signed({1'b0, level});   // level taken as positive

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= synth_pkg::ST_IDLE;
            level <= '0;
            start_p <= 1'b0;
            release_p <= 1'b0;
            reset_p <= 1'b0;
            step_valid <= 1'b0;
            fin_d <= 1'b0;
            out_valid <= 1'b0;
            note_finished <= 1'b0;
        end else begin
            step_valid <= in_valid;
            out_valid <= step_valid;
            note_finished <= fin_d;
            fin_d <= 1'b0;
            // strobes wait here for the next sample
            if (note_start)
                start_p <= 1'b1;
            if (note_release)
                release_p <= 1'b1;
            if (note_reset)
                reset_p <= 1'b1;
            if (global_reset) begin
                state <= synth_pkg::ST_IDLE;
                level <= '0;
                start_p <= 1'b0;
                release_p <= 1'b0;
                reset_p <= 1'b0;
            end else if (in_valid) begin
                start_p <= 1'b0;
                release_p <= 1'b0;
                reset_p <= 1'b0;
                if (reset_p || note_reset) begin
                    state <= synth_pkg::ST_IDLE;
                    level <= '0;
                end else if (start_p || note_start) begin
                    state <= synth_pkg::ST_ATTACK;        // retrigger from current level
                end else if ((release_p || note_release) && state != synth_pkg::ST_IDLE) begin
                    state <= synth_pkg::ST_RELEASE;
                end else begin
                    case (state)
                        synth_pkg::ST_ATTACK: begin
                            if (level >= synth_pkg::ENV_MAX - synth_pkg::ATTACK_STEP) begin
                                level <= synth_pkg::ENV_MAX;
                                state <= synth_pkg::ST_DECAY;
                            end else begin
                                level <= level + synth_pkg::ATTACK_STEP;
                            end
                        end
                        synth_pkg::ST_DECAY: begin
                            if (level <= synth_pkg::SUSTAIN_LEVEL + synth_pkg::DECAY_STEP) begin
                                level <= synth_pkg::SUSTAIN_LEVEL;
                                state <= synth_pkg::ST_SUSTAIN;
                            end else begin
                                level <= level - synth_pkg::DECAY_STEP;
                            end
                        end
                        synth_pkg::ST_RELEASE: begin
                            if (level <= synth_pkg::RELEASE_STEP) begin
                                level <= '0;
                                state <= synth_pkg::ST_IDLE;
                                fin_d <= 1'b1;
                            end else begin
                                level <= level - synth_pkg::RELEASE_STEP;
                            end
                        end
                        default: ;                        // idle and sustain hold
                    endcase
                end
            end
        end
    end

    // second cycle, scale the sample by the new level
    always_ff @(posedge clk) begin
        if (in_valid)
            wave_d <= wave_in;
        if (step_valid)
            wave_out <= prod[synth_pkg::WAVE_W+synth_pkg::ENV_W-1:synth_pkg::ENV_W];
    end

endmodule

/* hw/gain_and_truncate.sv */
`timescale 1ns/1ps

module gain_and_truncate (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic [synth_pkg::SHIFT_W-1:0] global_shift,
    input  logic signed [synth_pkg::MIX_W-1:0] wave_in,
    output logic signed [synth_pkg::OUT_W-1:0] wave,
    output logic out_valid
);
    logic signed [synth_pkg::MIX_W-1:0] shifted;

    assign shifted = wave_in >>> global_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            wave <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                if (shifted > 2**(synth_pkg::OUT_W-1) - 1)
                    wave <= {1'b0, {(synth_pkg::OUT_W-1){1'b1}}};   // clip high
                else if (shifted < -(2**(synth_pkg::OUT_W-1)))
                    wave <= {1'b1, {(synth_pkg::OUT_W-1){1'b0}}};   // clip low
                else
                    wave <= shifted[synth_pkg::OUT_W-1:0];
            end
        end
    end

endmodule

/* hw/wave_generator.sv */
`timescale 1ns/1ps

module wave_generator (
    input  logic clk,
    input  logic rst,
    input  logic global_reset,
    input  logic [synth_pkg::SHIFT_W-1:0] global_shift,
    input  logic [synth_pkg::SHIFT_W-1:0] square_shift,
    input  logic [synth_pkg::SHIFT_W-1:0] triangle_shift,
    input  logic [synth_pkg::SHIFT_W-1:0] sawtooth_shift,
    input  logic [synth_pkg::PHASE_W-1:0] increment_1,
    input  logic note_start_1,
    input  logic note_release_1,
    input  logic note_reset_1,
    output logic note_finished_1,
    input  logic [synth_pkg::PHASE_W-1:0] increment_2,
    input  logic note_start_2,
    input  logic note_release_2,
    input  logic note_reset_2,
    output logic note_finished_2,
    input  logic [synth_pkg::PHASE_W-1:0] increment_3,
    input  logic note_start_3,
    input  logic note_release_3,
    input  logic note_reset_3,
    output logic note_finished_3,
    input  logic [synth_pkg::PHASE_W-1:0] increment_4,
    input  logic note_start_4,
    input  logic note_release_4,
    input  logic note_reset_4,
    output logic note_finished_4,
    output logic signed [synth_pkg::OUT_W-1:0] wave,
    output logic valid
);
    logic nco_valid;
    logic signed [synth_pkg::WAVE_W-1:0] nco_wave [4];
    logic signed [synth_pkg::WAVE_W-1:0] svf_wave [4];
    logic signed [synth_pkg::WAVE_W-1:0] env_wave [4];
    logic [3:0] svf_valid;
    logic [3:0] env_valid;
    logic [3:0] start_v;
    logic [3:0] rel_v;
    logic [3:0] rst_v;
    logic [3:0] fin_v;
    logic signed [synth_pkg::MIX_W-1:0] wave_sum;
    logic valid_sum;

    assign start_v = {note_start_4, note_start_3, note_start_2, note_start_1};
    assign rel_v = {note_release_4, note_release_3, note_release_2, note_release_1};
    assign rst_v = {note_reset_4, note_reset_3, note_reset_2, note_reset_1};
    assign {note_finished_4, note_finished_3, note_finished_2, note_finished_1} = fin_v;

    nco i_nco (
        .clk(clk),
        .rst(rst),
        .increment_1(increment_1),
        .increment_2(increment_2),
        .increment_3(increment_3),
        .increment_4(increment_4),
        .square_shift(square_shift),
        .triangle_shift(triangle_shift),
        .sawtooth_shift(sawtooth_shift),
        .wave_1(nco_wave[0]),
        .wave_2(nco_wave[1]),
        .wave_3(nco_wave[2]),
        .wave_4(nco_wave[3]),
        .valid(nco_valid)
    );

    // -------------------------------------------------------------------------
    // voice chains, filter then envelope
    // -------------------------------------------------------------------------
    for (genvar i = 0; i < 4; i++) begin : g_voice
        svf i_svf (
            .clk(clk),
            .rst(rst),
            .in_valid(nco_valid),
            .x(nco_wave[i]),
            .y(svf_wave[i]),
            .out_valid(svf_valid[i])
        );

        adsr i_adsr (
            .clk(clk),
            .rst(rst),
            .global_reset(global_reset),
            .in_valid(svf_valid[i]),
            .wave_in(svf_wave[i]),
            .note_start(start_v[i]),
            .note_release(rel_v[i]),
            .note_reset(rst_v[i]),
            .wave_out(env_wave[i]),
            .note_finished(fin_v[i]),
            .out_valid(env_valid[i])
        );
    end

    // voice sum, sign-extended to MIX_W
    always_ff @(posedge clk) begin
        if (rst)
            valid_sum <= 1'b0;
        else
            valid_sum <= |env_valid;
        if (|env_valid)
            wave_sum <= env_wave[0] + env_wave[1] + env_wave[2] + env_wave[3];
    end

    gain_and_truncate i_gain_and_truncate (
        .clk(clk),
        .rst(rst),
        .in_valid(valid_sum),
        .global_shift(global_shift),
        .wave_in(wave_sum),
        .wave(wave),
        .out_valid(valid)
    );

endmodule

/* sim/wave_generator_tb.sv */
`timescale 1ns/1ps

module wave_generator_tb;

    localparam int SCRIPT_SAMPLES = 215;     // sum of all note script waits
    localparam int MAX_CYCLES = 4 * SCRIPT_SAMPLES * synth_pkg::SAMPLE_DIV;
    localparam int M_IDLE = 0;
    localparam int M_ATTACK = 1;
    localparam int M_DECAY = 2;
    localparam int M_SUSTAIN = 3;
    localparam int M_RELEASE = 4;

    logic clk;
    logic rst;
    logic global_reset;
    logic [synth_pkg::SHIFT_W-1:0] global_shift;
    logic [synth_pkg::SHIFT_W-1:0] square_shift;
    logic [synth_pkg::SHIFT_W-1:0] triangle_shift;
    logic [synth_pkg::SHIFT_W-1:0] sawtooth_shift;
    logic [synth_pkg::PHASE_W-1:0] increment_1;
    logic [synth_pkg::PHASE_W-1:0] increment_2;
    logic [synth_pkg::PHASE_W-1:0] increment_3;
    logic [synth_pkg::PHASE_W-1:0] increment_4;
    logic [3:0] start_v;
    logic [3:0] release_v;
    logic [3:0] reset_v;
    logic [3:0] fin_vec;
    logic signed [synth_pkg::OUT_W-1:0] wave;
    logic valid;

    int errors = 0;
    int cycles = 0;
    int rst_cycles = 0;
    int since_valid = 0;
    int fin_pulses = 0;
    logic first_seen = 1'b0;
    logic [31:0] lcg_state;
    logic mute_chk;

    // envelope model state
    int lvl [4];
    int st [4];
    int steps_since [4];
    logic [3:0] pend_start;
    logic [3:0] pend_release;
    logic [3:0] pend_reset;
    logic [3:0] fin_now;
    logic [3:0] fin_seen;
    logic [3:0] got_fin;
    logic [3:0] exp_fin;
    logic chk_valid = 1'b0;
    logic exp_silent;
    logic mute_q;
    logic sustain_q;
    logic full_q;
    logic seen_nonzero = 1'b0;
    logic seen_clip = 1'b0;

    wave_generator i_wave_generator (
        .clk(clk),
        .rst(rst),
        .global_reset(global_reset),
        .global_shift(global_shift),
        .square_shift(square_shift),
        .triangle_shift(triangle_shift),
        .sawtooth_shift(sawtooth_shift),
        .increment_1(increment_1),
        .note_start_1(start_v[0]),
        .note_release_1(release_v[0]),
        .note_reset_1(reset_v[0]),
        .note_finished_1(fin_vec[0]),
        .increment_2(increment_2),
        .note_start_2(start_v[1]),
        .note_release_2(release_v[1]),
        .note_reset_2(reset_v[1]),
        .note_finished_2(fin_vec[1]),
        .increment_3(increment_3),
        .note_start_3(start_v[2]),
        .note_release_3(release_v[2]),
        .note_reset_3(reset_v[2]),
        .note_finished_3(fin_vec[2]),
        .increment_4(increment_4),
        .note_start_4(start_v[3]),
        .note_release_4(release_v[3]),
        .note_reset_4(reset_v[3]),
        .note_finished_4(fin_vec[3]),
        .wave(wave),
        .valid(valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic set_increments();
        lcg_state = lcg_next(lcg_state);
        increment_1 <= lcg_state[31:8];
        lcg_state = lcg_next(lcg_state);
        increment_2 <= lcg_state[31:8];
        lcg_state = lcg_next(lcg_state);
        increment_3 <= lcg_state[31:8];
        lcg_state = lcg_next(lcg_state);
        increment_4 <= lcg_state[31:8];
    endtask

    // returns on the edge where valid is seen high
    task automatic wait_samples(input int n);
        repeat (n) begin
            @(posedge clk);
            while (valid !== 1'b1)
                @(posedge clk);
        end
    endtask

    task automatic pulse_strobes(input logic [3:0] s, input logic [3:0] r, input logic [3:0] x);
        start_v <= s;
        release_v <= r;
        reset_v <= x;
        @(posedge clk);
        start_v <= '0;
        release_v <= '0;
        reset_v <= '0;
    endtask

    // ------------------------------------------------------------------------
    // envelope reference model, one step per output sample
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            for (int v = 0; v < 4; v++) begin
                lvl[v] = 0;
                st[v] = M_IDLE;
                steps_since[v] = 0;
            end
            pend_start = '0;
            pend_release = '0;
            pend_reset = '0;
            chk_valid <= 1'b0;
        end else begin
            fin_now = '0;
            for (int v = 0; v < 4; v++) begin
                if (start_v[v] || release_v[v] || reset_v[v])
                    steps_since[v] = 0;
            end
            pend_start = pend_start | start_v;
            pend_release = pend_release | release_v;
            pend_reset = pend_reset | reset_v;
            if (global_reset) begin                     // level, holds all voices idle
                for (int v = 0; v < 4; v++) begin
                    lvl[v] = 0;
                    st[v] = M_IDLE;
                end
                pend_start = '0;
                pend_release = '0;
                pend_reset = '0;
            end else if (valid) begin
                for (int v = 0; v < 4; v++) begin
                    steps_since[v]++;
                    if (pend_reset[v]) begin
                        lvl[v] = 0;
                        st[v] = M_IDLE;
                    end else if (pend_start[v]) begin
                        st[v] = M_ATTACK;               // no step on the sample that starts
                    end else if (pend_release[v] && st[v] != M_IDLE) begin
                        st[v] = M_RELEASE;
                    end else if (st[v] == M_ATTACK) begin
                        lvl[v] = lvl[v] + int'(synth_pkg::ATTACK_STEP);
                        if (lvl[v] >= int'(synth_pkg::ENV_MAX)) begin
                            lvl[v] = int'(synth_pkg::ENV_MAX);
                            st[v] = M_DECAY;
                        end
                    end else if (st[v] == M_DECAY) begin
                        lvl[v] = lvl[v] - int'(synth_pkg::DECAY_STEP);
                        if (lvl[v] <= int'(synth_pkg::SUSTAIN_LEVEL)) begin
                            lvl[v] = int'(synth_pkg::SUSTAIN_LEVEL);
                            st[v] = M_SUSTAIN;
                        end
                    end else if (st[v] == M_RELEASE) begin
                        lvl[v] = lvl[v] - int'(synth_pkg::RELEASE_STEP);
                        if (lvl[v] <= 0) begin
                            lvl[v] = 0;
                            st[v] = M_IDLE;
                            fin_now[v] = 1'b1;
                            $display("voice %0d finished %0d samples after its strobe",
                                     v + 1, steps_since[v]);
                        end
                    end
                end
                pend_start = '0;
                pend_release = '0;
                pend_reset = '0;
            end
            chk_valid <= valid;
            got_fin <= fin_seen;
            exp_fin <= fin_now;
            exp_silent <= (lvl[0] == 0 && lvl[1] == 0 && lvl[2] == 0 && lvl[3] == 0);
            sustain_q <= (st[0] == M_SUSTAIN || st[1] == M_SUSTAIN
                          || st[2] == M_SUSTAIN || st[3] == M_SUSTAIN);
            full_q <= (lvl[0] >= int'(synth_pkg::SUSTAIN_LEVEL)
                       && lvl[1] >= int'(synth_pkg::SUSTAIN_LEVEL)
                       && lvl[2] >= int'(synth_pkg::SUSTAIN_LEVEL)
                       && lvl[3] >= int'(synth_pkg::SUSTAIN_LEVEL));
            mute_q <= mute_chk;
        end
    end

    // note_finished leads valid by two cycles, collect it per sample
    always @(posedge clk) begin
        if (rst)
            fin_seen <= '0;
        else if (valid)
            fin_seen <= fin_vec;
        else
            fin_seen <= fin_seen | fin_vec;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst)
            rst_cycles <= rst_cycles + 1;
        if (rst) begin
            since_valid <= 0;
            first_seen <= 1'b0;
        end else if (valid) begin
            since_valid <= 1;
            first_seen <= 1'b1;
        end else begin
            since_valid <= since_valid + 1;
        end
        if (!rst)
            fin_pulses <= fin_pulses + $countones(fin_vec);
        if (chk_valid && sustain_q && wave != '0)
            seen_nonzero <= 1'b1;
        if (chk_valid && full_q && (wave == 12'sh7ff || wave == 12'sh800))
            seen_clip <= 1'b1;
        if (cycles == MAX_CYCLES) begin
            errors = errors + 1;
            $display("timeout, the note scripts did not finish in %0d cycles", MAX_CYCLES);
            $display("errors: %0d", errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        (rst && rst_cycles > 0) |-> (valid == 1'b0 && wave == '0 && fin_vec == '0))
    else begin
        errors++;
        $display("FAIL reset outputs: valid=%h wave=%h note_finished=%h, expected 0",
                 $sampled(valid), $sampled(wave), $sampled(fin_vec));
    end

    a_cadence: assert property (@(posedge clk) disable iff (rst)
        first_seen |-> (valid ? since_valid == synth_pkg::SAMPLE_DIV
                              : since_valid < synth_pkg::SAMPLE_DIV))
    else begin
        errors++;
        $display("valid cadence broken, %0d cycles since the previous valid",
                 $sampled(since_valid));
    end

    a_silence: assert property (@(posedge clk) disable iff (rst)
        (chk_valid && exp_silent) |-> wave == '0)
    else begin
        errors++;
        $display("FAIL wave (all voices idle): got %h expected %h", $sampled(wave), 12'h0);
    end

    a_muted: assert property (@(posedge clk) disable iff (rst)
        (chk_valid && mute_q) |-> wave == '0)
    else begin
        errors++;
        $display("FAIL wave (shapes muted): got %h expected %h", $sampled(wave), 12'h0);
    end

    a_finished: assert property (@(posedge clk) disable iff (rst)
        chk_valid |-> got_fin == exp_fin)
    else begin
        errors++;
        $display("FAIL note_finished: got %h expected %h", $sampled(got_fin), $sampled(exp_fin));
    end

    // ------------------------------------------------------------------------
    // note scripts
    // ------------------------------------------------------------------------
    initial begin
        rst = 1'b1;
        global_reset = 1'b0;
        global_shift = '0;
        square_shift = '1;
        triangle_shift = '1;
        sawtooth_shift = '1;
        increment_1 = '0;
        increment_2 = '0;
        increment_3 = '0;
        increment_4 = '0;
        start_v = '0;
        release_v = '0;
        reset_v = '0;
        mute_chk = 1'b1;
        lcg_state = 32'hc715e207;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        set_increments();
        wait_samples(2);

        pulse_strobes(4'hf, 4'h0, 4'h0);                // all voices sound, shapes muted
        wait_samples(40);
        pulse_strobes(4'h0, 4'h0, 4'hf);
        wait_samples(3);
        mute_chk <= 1'b0;
        square_shift <= '0;
        triangle_shift <= '0;
        sawtooth_shift <= '0;
        set_increments();

        pulse_strobes(4'h1, 4'h0, 4'h0);                // full envelope on voice 1
        wait_samples(40);
        pulse_strobes(4'h0, 4'h1, 4'h0);
        wait_samples(20);

        pulse_strobes(4'h2, 4'h0, 4'h0);
        wait_samples(20);
        pulse_strobes(4'h0, 4'h0, 4'h2);                // cut voice 2 mid decay
        wait_samples(4);
        set_increments();
        pulse_strobes(4'hd, 4'h0, 4'h0);
        wait_samples(20);
        global_reset <= 1'b1;
        wait_samples(2);
        global_reset <= 1'b0;
        wait_samples(4);

        set_increments();
        pulse_strobes(4'hf, 4'h0, 4'h0);                // drive the output into clipping
        wait_samples(40);
        pulse_strobes(4'h0, 4'hf, 4'h0);
        wait_samples(20);
        repeat (2) @(posedge clk);

        a_sustain_sound: assert (seen_nonzero)
        else begin
            errors++;
            $display("no nonzero sample while a voice was in sustain");
        end
        a_clip_reached: assert (seen_clip)
        else begin
            errors++;
            $display("output never reached full scale with all four voices sounding");
        end
        a_fin_total: assert (fin_pulses == 5)
        else begin
            errors++;
            $display("FAIL note_finished pulse count: got %h expected %h", fin_pulses, 5);
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
hw/synth_pkg.sv
hw/nco.sv
hw/svf.sv
hw/adsr.sv
hw/gain_and_truncate.sv
hw/wave_generator.sv
sim/wave_generator_tb.sv
